//--- common/seed_params.svh
// Seed extension sizing macros shared by packages and RTL
`ifndef SEED_PARAMS_SVH
`define SEED_PARAMS_SVH

// Fragment and k-mer lengths in bases
`define SEED_FRAG_LEN 32
`define SEED_KMER_LEN 8

// Index slots kept per fragment
`define SEED_SLOTS 4

// Bases sent per output cycle
`define SEED_PART_BASES 4

// Fragment position width, 0 to 31
`define SEED_POS_BITS 5

// Signed index after centring
`define SEED_IDX_BITS 6

// Output parts per fragment
`define SEED_PARTS (`SEED_FRAG_LEN / `SEED_PART_BASES)

// Last position where the whole k-mer still fits
`define SEED_SCAN_LAST (`SEED_FRAG_LEN - `SEED_KMER_LEN)

`endif

//--- common/dna_pkg.sv
// DNA package with base codes, one-hot bases, fragment word and part types
`include "seed_params.svh"

package dna_pkg;

    // Two-bit base code
    typedef logic [1:0] base_t;

    localparam base_t BASE_A = 2'b00;
    localparam base_t BASE_C = 2'b01;
    localparam base_t BASE_G = 2'b10;
    localparam base_t BASE_T = 2'b11;

    // Bit n set for code n
    typedef logic [3:0] onehot_t;

    // Fragment word, moved as raw bits and decoded per base
    typedef union packed {
        logic [2*`SEED_FRAG_LEN-1:0] raw;
        base_t [`SEED_FRAG_LEN-1:0]  bases;
    } frag_word_u;

    // Query k-mer, base 0 in the low bits
    typedef base_t [`SEED_KMER_LEN-1:0] kmer_t;

    // One output part of one-hot bases
    typedef onehot_t [`SEED_PART_BASES-1:0] gfm_part_t;

endpackage

//--- common/seed_pkg.sv
// Seed package with fragment positions, signed indices and the index set
`include "seed_params.svh"

package seed_pkg;

    // Alignment position inside a fragment
    typedef logic [`SEED_POS_BITS-1:0] pos_t;

    // Centred position, negative left of the middle
    typedef logic signed [`SEED_IDX_BITS-1:0] sidx_t;

    // Hit positions of one fragment, slot 0 is the first hit found
    typedef struct packed {
        pos_t [`SEED_SLOTS-1:0]  hits;
        logic [`SEED_SLOTS-1:0]  hit_mask;
    } index_set_t;

endpackage

//--- seed_finder/seed_finder.sv
// Seed finder: scans all k-mer alignments in a fragment and keeps the first hits
`timescale 1ns/1ps
`include "seed_params.svh"

module seed_finder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  frag_valid,
    input  dna_pkg::frag_word_u   fragment,
    input  dna_pkg::kmer_t        kmer,
    input  logic                  pending_full,
    output logic                  busy,
    output logic                  set_valid,
    output dna_pkg::frag_word_u   set_frag,
    output seed_pkg::index_set_t  set_indices
);

    localparam int SLOT_W = $clog2(`SEED_SLOTS);

    dna_pkg::frag_word_u                   frag_r;
    dna_pkg::kmer_t                        kmer_r;
    logic                                  busy_r;
    logic                                  scanning;
    seed_pkg::pos_t                        pos_r;
    logic [SLOT_W:0]                       fill_cnt;
    logic [`SEED_SLOTS-1:0]                mask_r;
    seed_pkg::pos_t [`SEED_SLOTS-1:0]      hits_r;
    logic                                  accept;
    logic                                  match;
    logic                                  slots_full;
    logic                                  take_hit;

    assign accept     = frag_valid && !busy_r;
    assign slots_full = (fill_cnt == (SLOT_W+1)'(`SEED_SLOTS));
    assign take_hit   = scanning && match && !slots_full;

    // Compare the k-mer against the bases at the current position
    always_comb begin
        match = 1'b1;
        for (int i = 0; i < `SEED_KMER_LEN; i++) begin
            if (frag_r.bases[pos_r + i] != kmer_r[i]) begin
                match = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_r   <= 1'b0;
            scanning <= 1'b0;
            pos_r    <= '0;
            fill_cnt <= '0;
            mask_r   <= '0;
        end else if (accept) begin
            busy_r   <= 1'b1;
            scanning <= 1'b1;
            pos_r    <= '0;
            fill_cnt <= '0;
            mask_r   <= '0;
        end else if (scanning) begin
            if (take_hit) begin
                mask_r[fill_cnt[SLOT_W-1:0]] <= 1'b1;
                fill_cnt <= fill_cnt + 1'b1;
            end
            if (pos_r == seed_pkg::pos_t'(`SEED_SCAN_LAST)) begin
                scanning <= 1'b0;
            end else begin
                pos_r <= pos_r + 1'b1;
            end
        end else if (set_valid) begin
            busy_r <= 1'b0;
        end
    end

    // Fragment, k-mer and hit positions
    always_ff @(posedge clk) begin
        if (accept) begin
            frag_r <= fragment;
            kmer_r <= kmer;
            hits_r <= '0;
        end else if (take_hit) begin
            hits_r[fill_cnt[SLOT_W-1:0]] <= pos_r;
        end
    end

    // Result waits here until the buffer has room
    assign set_valid   = busy_r && !scanning && !pending_full;
    assign busy        = busy_r;
    assign set_frag    = frag_r;
    assign set_indices = '{hits: hits_r, hit_mask: mask_r};

endmodule

//--- source/seed_buffer.sv
// Seed buffer: pending and active fragment store, promoted at window ends
`timescale 1ns/1ps
`include "seed_params.svh"

module seed_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  set_valid,
    input  dna_pkg::frag_word_u   set_frag,
    input  seed_pkg::index_set_t  set_indices,
    input  logic                  window_end,
    output logic                  pending_full,
    output logic                  load,
    output dna_pkg::frag_word_u   act_frag,
    output seed_pkg::index_set_t  act_indices
);

    dna_pkg::frag_word_u   pend_frag;
    seed_pkg::index_set_t  pend_idx;
    dna_pkg::frag_word_u   act_frag_r;
    seed_pkg::index_set_t  act_idx_r;
    logic                  pend_full_r;

    // Promote only when something waits
    assign load = window_end && pend_full_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_full_r <= 1'b0;
        end else if (set_valid) begin
            pend_full_r <= 1'b1;
        end else if (load) begin
            pend_full_r <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (set_valid) begin
            pend_frag <= set_frag;
            pend_idx  <= set_indices;
        end
    end

    // Active entry changes only at a window boundary
    always_ff @(posedge clk) begin
        if (load) begin
            act_frag_r <= pend_frag;
            act_idx_r  <= pend_idx;
        end
    end

    assign pending_full = pend_full_r;

    // The extender streams the fragment until the last cycle of the window
    assign act_frag = act_frag_r;

    // Index set shows the incoming entry during load, so the extender
    // registers the new set at the promoting edge
    assign act_indices = load ? pend_idx : act_idx_r;

endmodule

//--- extender/seed_extender.sv
// Seed extender: streams the active fragment as one-hot parts with centred slot indices
`timescale 1ns/1ps
`include "seed_params.svh"

module seed_extender (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load,
    input  dna_pkg::frag_word_u   act_frag,
    input  seed_pkg::index_set_t  act_indices,
    output logic                  window_end,
    output dna_pkg::gfm_part_t    out_gfm,
    output seed_pkg::sidx_t       out_index,
    output logic                  out_hit,
    output logic                  out_valid
);

    localparam int PART_W = $clog2(`SEED_PARTS);
    localparam int SLOT_W = $clog2(`SEED_SLOTS);
    localparam seed_pkg::sidx_t CENTRE =
        seed_pkg::sidx_t'((`SEED_FRAG_LEN - `SEED_KMER_LEN) / 2);

    logic [PART_W-1:0]                   part;
    logic [SLOT_W-1:0]                   slot;
    logic                                part_wrap;
    logic                                active;
    seed_pkg::pos_t [`SEED_SLOTS-1:0]    hits_r;
    logic [`SEED_SLOTS-1:0]              mask_r;
    dna_pkg::base_t [`SEED_PART_BASES-1:0] part_bases;

    assign part_wrap  = (part == PART_W'(`SEED_PARTS - 1));
    assign window_end = part_wrap && (slot == SLOT_W'(`SEED_SLOTS - 1));

    // Free-running window counters, never restarted by a load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            part <= '0;
            slot <= '0;
        end else begin
            part <= part_wrap ? '0 : part + 1'b1;
            if (part_wrap) begin
                slot <= slot + 1'b1;
            end
        end
    end

    // Active flag and hit mask follow the buffer at each window end
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            mask_r <= '0;
        end else if (window_end) begin
            active <= load;
            mask_r <= load ? act_indices.hit_mask : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            hits_r <= act_indices.hits;
        end
    end

    assign part_bases = act_frag.bases[part*`SEED_PART_BASES +: `SEED_PART_BASES];

    // Base code to one-hot nibble
    always_comb begin
        for (int i = 0; i < `SEED_PART_BASES; i++) begin
            case (part_bases[i])
                dna_pkg::BASE_A: out_gfm[i] = 4'b0001;
                dna_pkg::BASE_C: out_gfm[i] = 4'b0010;
                dna_pkg::BASE_G: out_gfm[i] = 4'b0100;
                dna_pkg::BASE_T: out_gfm[i] = 4'b1000;
                default:         out_gfm[i] = 4'b0000;
            endcase
        end
    end

    // Hit position relative to the fragment centre
    assign out_index = seed_pkg::sidx_t'({1'b0, hits_r[slot]}) - CENTRE;
    assign out_hit   = mask_r[slot];
    assign out_valid = active;

endmodule

//--- source/seed_extend_top.sv
// Seed extension front end: finder, two-entry buffer and one-hot extender
`timescale 1ns/1ps
`include "seed_params.svh"

module seed_extend_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 frag_valid,
    input  dna_pkg::frag_word_u  fragment,
    input  dna_pkg::kmer_t       kmer,
    output logic                 busy,
    output dna_pkg::gfm_part_t   out_gfm,
    output seed_pkg::sidx_t      out_index,
    output logic                 out_hit,
    output logic                 out_valid
);

    logic                  set_valid;
    dna_pkg::frag_word_u   set_frag;
    seed_pkg::index_set_t  set_indices;
    logic                  pending_full;
    logic                  window_end;
    logic                  load;
    dna_pkg::frag_word_u   act_frag;
    seed_pkg::index_set_t  act_indices;

    seed_finder u_finder (
        .clk          (clk),
        .rst_n        (rst_n),
        .frag_valid   (frag_valid),
        .fragment     (fragment),
        .kmer         (kmer),
        .pending_full (pending_full),
        .busy         (busy),
        .set_valid    (set_valid),
        .set_frag     (set_frag),
        .set_indices  (set_indices)
    );

    seed_buffer u_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .set_valid    (set_valid),
        .set_frag     (set_frag),
        .set_indices  (set_indices),
        .window_end   (window_end),
        .pending_full (pending_full),
        .load         (load),
        .act_frag     (act_frag),
        .act_indices  (act_indices)
    );

    seed_extender u_extender (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (load),
        .act_frag     (act_frag),
        .act_indices  (act_indices),
        .window_end   (window_end),
        .out_gfm      (out_gfm),
        .out_index    (out_index),
        .out_hit      (out_hit),
        .out_valid    (out_valid)
    );

endmodule

//--- sim/seed_extend_tb.sv
// Testbench for the seed extension front end with LFSR stimulus and a reference model
`timescale 1ns/1ps
`include "seed_params.svh"

module seed_extend_tb;

    localparam int NUM_FRAGS  = 12;
    localparam int MAX_CYCLES = NUM_FRAGS * 100 + 200;
    localparam int CENTRE     = (`SEED_FRAG_LEN - `SEED_KMER_LEN) / 2;
    localparam int WINDOW     = `SEED_SLOTS * `SEED_PARTS;

    logic                 clk;
    logic                 rst_n;
    logic                 frag_valid;
    dna_pkg::frag_word_u  fragment;
    dna_pkg::kmer_t       kmer;
    logic                 busy;
    dna_pkg::gfm_part_t   out_gfm;
    seed_pkg::sidx_t      out_index;
    logic                 out_hit;
    logic                 out_valid;

    logic [31:0]          lfsr_state;
    dna_pkg::frag_word_u  exp_frags[$];
    dna_pkg::kmer_t       exp_kmers[$];
    int                   accepted_cnt;
    int                   windows_done;
    int                   cycle_cnt;

    seed_extend_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .frag_valid (frag_valid),
        .fragment   (fragment),
        .kmer       (kmer),
        .busy       (busy),
        .out_gfm    (out_gfm),
        .out_index  (out_index),
        .out_hit    (out_hit),
        .out_valid  (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Right-shifting Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic dna_pkg::kmer_t copy_kmer(input dna_pkg::frag_word_u frag, input int pos);
        dna_pkg::kmer_t k;
        for (int i = 0; i < `SEED_KMER_LEN; i++) begin
            k[i] = frag.raw[2*(pos+i) +: 2];
        end
        return k;
    endfunction

    // First four alignment positions where all k-mer bases agree
    function automatic seed_pkg::index_set_t ref_index_set(input dna_pkg::frag_word_u frag,
                                                          input dna_pkg::kmer_t km);
        seed_pkg::index_set_t r;
        int                   n;
        logic                 same;
        r = '0;
        n = 0;
        for (int p = 0; p <= `SEED_FRAG_LEN - `SEED_KMER_LEN; p++) begin
            same = 1'b1;
            for (int i = 0; i < `SEED_KMER_LEN; i++) begin
                if (frag.raw[2*(p+i) +: 2] != km[i]) begin
                    same = 1'b0;
                end
            end
            if (same && n < `SEED_SLOTS) begin
                r.hits[n]     = seed_pkg::pos_t'(p);
                r.hit_mask[n] = 1'b1;
                n++;
            end
        end
        return r;
    endfunction

    // Nibble i carries the one-hot code of base part*4+i
    function automatic logic [15:0] expected_part(input dna_pkg::frag_word_u frag, input int part);
        logic [15:0] r;
        logic [1:0]  code;
        for (int i = 0; i < `SEED_PART_BASES; i++) begin
            code         = frag.raw[2*(part*`SEED_PART_BASES+i) +: 2];
            r[4*i +: 4]  = 4'b0001 << code;
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "stopped at first wrong value");
        end
    endtask

    // Strobes while busy carry junk and must be ignored by the DUT
    task automatic send_fragment(input dna_pkg::frag_word_u frag, input dna_pkg::kmer_t km,
                                 input logic junk);
        logic [63:0] bits;
        while (busy) begin
            if (junk) begin
                take_bits(64, bits);
                fragment.raw = bits;
                frag_valid   = 1'b1;
            end else begin
                frag_valid = 1'b0;
            end
            @(negedge clk);
        end
        fragment   = frag;
        kmer       = km;
        frag_valid = 1'b1;
        exp_frags.push_back(frag);
        exp_kmers.push_back(km);
        accepted_cnt++;
        @(negedge clk);
        frag_valid = 1'b0;
        // Busy rises at the accepting edge
        check_value("busy", 32'd1, busy);
    endtask

    initial begin : stimulus
        dna_pkg::frag_word_u frag;
        dna_pkg::kmer_t      km;
        logic [63:0]         bits;
        rst_n        = 1'b0;
        frag_valid   = 1'b0;
        fragment     = '0;
        kmer         = '0;
        lfsr_state   = 32'h8ca0;
        accepted_cnt = 0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Single hits left of, right of and at the centre
        take_bits(64, bits);
        frag.raw = bits;
        send_fragment(frag, copy_kmer(frag, 3), 1'b0);
        take_bits(64, bits);
        frag.raw = bits;
        send_fragment(frag, copy_kmer(frag, 20), 1'b0);
        take_bits(64, bits);
        frag.raw = bits;
        send_fragment(frag, copy_kmer(frag, 12), 1'b0);

        // All G, so only positions 0 to 3 are kept
        frag.raw = {32{2'b10}};
        send_fragment(frag, {8{2'b10}}, 1'b0);

        // Random k-mer that normally has no hit
        take_bits(64, bits);
        frag.raw = bits;
        take_bits(16, bits);
        km = bits[15:0];
        send_fragment(frag, km, 1'b0);

        // Let the output drain and go idle before the next burst
        wait (windows_done == accepted_cnt);
        repeat (40) @(negedge clk);

        // ACGT repeated covers every code in every part
        for (int j = 0; j < `SEED_FRAG_LEN; j++) begin
            frag.raw[2*j +: 2] = 2'(j % 4);
        end
        send_fragment(frag, copy_kmer(frag, 0), 1'b0);

        for (int f = 6; f < NUM_FRAGS; f++) begin
            take_bits(64, bits);
            frag.raw = bits;
            take_bits(1, bits);
            if (bits[0]) begin
                take_bits(5, bits);
                km = copy_kmer(frag, int'(bits[4:0]) % (`SEED_SCAN_LAST + 1));
            end else begin
                take_bits(16, bits);
                km = bits[15:0];
            end
            send_fragment(frag, km, 1'b1);
        end

        wait (windows_done == accepted_cnt);
        repeat (2 * WINDOW) begin
            @(negedge clk);
            check_value("out_valid", 32'd0, out_valid);
        end
        $display("Simulation passed");
        $finish;
    end

    initial begin : compare
        dna_pkg::frag_word_u  frag;
        seed_pkg::index_set_t exp_set;
        seed_pkg::sidx_t      exp_idx;
        int                   slot;
        int                   part;
        windows_done = 0;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            if (out_valid && exp_frags.size() == 0) begin
                $display("Error: out_valid rose with no accepted fragment waiting");
                $display("Simulation failed");
                $fatal(1, "unexpected output window");
            end else if (out_valid) begin
                frag    = exp_frags.pop_front();
                exp_set = ref_index_set(frag, exp_kmers.pop_front());
                for (int k = 0; k < WINDOW; k++) begin
                    if (k > 0) @(negedge clk);
                    slot    = k / `SEED_PARTS;
                    part    = k % `SEED_PARTS;
                    exp_idx = seed_pkg::sidx_t'(int'(exp_set.hits[slot]) - CENTRE);
                    check_value("out_valid", 32'd1, out_valid);
                    check_value("out_gfm", expected_part(frag, part), out_gfm);
                    check_value("out_index", exp_idx, out_index);
                    check_value("out_hit", exp_set.hit_mask[slot], out_hit);
                end
                windows_done++;
            end
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_cnt >= MAX_CYCLES) begin
                $display("Error: run did not finish within %0d cycles", MAX_CYCLES);
                $display("Simulation failed");
                $fatal(1, "timeout");
            end
        end
    end

endmodule

//--- project.f
+incdir+common
common/dna_pkg.sv
common/seed_pkg.sv
seed_finder/seed_finder.sv
source/seed_buffer.sv
extender/seed_extender.sv
source/seed_extend_top.sv
sim/seed_extend_tb.sv
